// File: verilog/mem_pkg.sv
package mem_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int data_width         = 32;
  localparam int ram_addr_bits      = 8;
  localparam int flash_addr_bits    = 24;
  localparam int page_words_default = 16;

  // Image location and the only instruction the SPI engine issues
  localparam logic [flash_addr_bits-1:0] flash_base     = 24'h080000;
  localparam logic [7:0]                 flash_read_cmd = 8'h03;

  // --------------------------------------------------
  // RAM bus
  // --------------------------------------------------
  typedef struct packed {
    logic                     write;
    logic                     read;
    logic [ram_addr_bits-1:0] addr;
    logic [data_width-1:0]    wdata;
  } ram_req_t;

  // rdata_valid follows a granted read by one cycle
  typedef struct packed {
    logic [data_width-1:0] rdata;
    logic                  rdata_valid;
  } ram_rsp_t;

  // --------------------------------------------------
  // Image words
  // --------------------------------------------------
  typedef struct packed {
    logic [15:0] reserved;
    logic [15:0] page_count;
  } image_header_t;

  // First word of the image is both stored data and the header
  typedef union packed {
    logic [data_width-1:0] data;
    image_header_t         header;
  } image_word_u;

endpackage

// File: verilog/spi_flash_reader.sv
`timescale 1ns/1ns

module spi_flash_reader (
  input  logic                                clk,
  input  logic                                reset_in,
  input  logic                                start,
  input  logic [mem_pkg::flash_addr_bits-1:0] addr,
  input  logic [9:0]                          byte_count,
  output logic                                busy,
  output logic [7:0]                          byte_data,
  output logic                                byte_valid,
  output logic                                flash_c,
  output logic                                flash_sb,
  output logic                                flash_dq0,
  input  logic                                flash_dq1
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_cmd  = 2'd1;
  localparam logic [1:0] st_data = 2'd2;
  localparam logic [1:0] st_done = 2'd3;

  logic [1:0]  state;
  logic [31:0] tx_shift;
  logic [7:0]  rx_shift;
  logic [4:0]  bit_cnt;
  logic [9:0]  bytes_left;

  assign busy      = (state != st_idle);
  assign flash_dq0 = tx_shift[31];

  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      state      <= st_idle;
      tx_shift   <= '0;
      rx_shift   <= '0;
      bit_cnt    <= '0;
      bytes_left <= '0;
      byte_data  <= '0;
      byte_valid <= 1'b0;
      flash_c    <= 1'b0;
      flash_sb   <= 1'b1;
    end else begin
      byte_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state      <= st_cmd;
            tx_shift   <= {mem_pkg::flash_read_cmd, addr};
            bit_cnt    <= 5'd31;
            bytes_left <= byte_count;
            flash_sb   <= 1'b0;
          end
        end
        // Command and address, MSB first
        st_cmd: begin
          flash_c <= ~flash_c;
          // Falling edge of flash_c moves the next bit out
          if (flash_c) begin
            if (bit_cnt == 5'd0) begin
              state    <= st_data;
              bit_cnt  <= 5'd7;
              tx_shift <= '0;
            end else begin
              tx_shift <= {tx_shift[30:0], 1'b0};
              bit_cnt  <= bit_cnt - 5'd1;
            end
          end
        end
        st_data: begin
          flash_c <= ~flash_c;
          // Sample on the rising edge, flash changed dq1 on the falling one
          if (!flash_c) begin
            rx_shift <= {rx_shift[6:0], flash_dq1};
            if (bit_cnt == 5'd0) begin
              byte_data  <= {rx_shift[6:0], flash_dq1};
              byte_valid <= 1'b1;
              bytes_left <= bytes_left - 10'd1;
              bit_cnt    <= 5'd7;
              if (bytes_left == 10'd1) begin
                state <= st_done;
              end
            end else begin
              bit_cnt <= bit_cnt - 5'd1;
            end
          end
        end
        st_done: begin
          flash_c  <= 1'b0;
          flash_sb <= 1'b1;
          state    <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Loader must wait for the previous transfer to end
  assert property (@(posedge clk) disable iff (reset_in) start |-> !busy)
    else $error("spi_flash_reader: start while a transfer is running");

endmodule

// File: verilog/boot_loader.sv
`timescale 1ns/1ns

module boot_loader #(
  parameter int page_words = mem_pkg::page_words_default
) (
  input  logic                                clk,
  input  logic                                reset_in,
  output logic                                flash_start,
  output logic [mem_pkg::flash_addr_bits-1:0] flash_addr,
  output logic [9:0]                          flash_byte_count,
  input  logic                                flash_busy,
  input  logic [7:0]                          byte_data,
  input  logic                                byte_valid,
  output logic                                req,
  output mem_pkg::ram_req_t                   req_data,
  input  logic                                gnt,
  output logic                                boot_active
);

  localparam int page_bytes = page_words * 4;
  localparam int word_bits  = $clog2(page_words) + 1;

  localparam logic [1:0] st_page = 2'd0;
  localparam logic [1:0] st_read = 2'd1;
  localparam logic [1:0] st_done = 2'd2;

  logic [1:0]                        state;
  logic [15:0]                       page;
  logic [15:0]                       page_count;
  logic                              header_valid;
  logic [word_bits-1:0]              word_idx;
  logic [1:0]                        byte_idx;
  mem_pkg::image_word_u              word_sr;
  mem_pkg::image_word_u              next_word;
  logic [mem_pkg::ram_addr_bits-1:0] word_addr;

  assign flash_byte_count = 10'(page_bytes);
  assign flash_addr = mem_pkg::flash_base
                    + mem_pkg::flash_addr_bits'(page) * mem_pkg::flash_addr_bits'(page_bytes);
  assign word_addr  = mem_pkg::ram_addr_bits'(page) * mem_pkg::ram_addr_bits'(page_words)
                    + mem_pkg::ram_addr_bits'(word_idx);

  // Bytes arrive most significant first
  assign next_word.data = {word_sr.data[23:0], byte_data};

  // --------------------------------------------------
  // Page sequencer
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      state        <= st_page;
      page         <= '0;
      page_count   <= '0;
      header_valid <= 1'b0;
      word_idx     <= '0;
      byte_idx     <= '0;
      flash_start  <= 1'b0;
      req          <= 1'b0;
      boot_active  <= 1'b1;
    end else begin
      flash_start <= 1'b0;
      if (gnt) begin
        req <= 1'b0;
      end
      case (state)
        st_page: begin
          if (header_valid && page >= page_count) begin
            state       <= st_done;
            boot_active <= 1'b0;
          end else begin
            state       <= st_read;
            flash_start <= 1'b1;
            word_idx    <= '0;
            byte_idx    <= '0;
          end
        end
        st_read: begin
          if (byte_valid) begin
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3) begin
              req      <= 1'b1;
              word_idx <= word_idx + 1'b1;
              // Header is word 0 of page 0
              if (page == 16'd0 && word_idx == '0) begin
                page_count   <= next_word.header.page_count;
                header_valid <= 1'b1;
              end
            end
          end
          // Page ends once the last write is granted and the link is idle
          if (word_idx == word_bits'(page_words) && !req && !flash_busy) begin
            page  <= page + 16'd1;
            state <= st_page;
          end
        end
        default: state <= st_done;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_read && byte_valid) begin
      word_sr <= next_word;
      if (byte_idx == 2'd3) begin
        req_data <= '{write: 1'b1, read: 1'b0, addr: word_addr, wdata: next_word.data};
      end
    end
  end

  // No back-pressure on the flash side, so each write is gone before the next word
  assert property (@(posedge clk) disable iff (reset_in)
    (byte_valid && byte_idx == 2'd3) |-> (!req || gnt))
    else $error("boot_loader: word completed before previous write was granted");

endmodule

// File: verilog/host_port.sv
`timescale 1ns/1ns

module host_port (
  input  logic                              clk,
  input  logic                              reset_in,
  input  logic                              write_req,
  input  logic                              read_req,
  input  logic [mem_pkg::ram_addr_bits-1:0] addr,
  input  logic [mem_pkg::data_width-1:0]    data_write,
  output logic [mem_pkg::data_width-1:0]    data_read,
  output logic                              data_read_valid,
  output logic                              busy,
  input  logic                              boot_active,
  output logic                              req,
  output mem_pkg::ram_req_t                 req_data,
  input  logic                              gnt,
  input  mem_pkg::ram_rsp_t                 rsp,
  input  logic                              rsp_mine
);

  logic pending;
  logic capture;
  logic read_done;

  // Strobes only count while the port is free
  assign capture   = !pending && !boot_active && (write_req || read_req);
  assign read_done = pending && !req && rsp.rdata_valid && rsp_mine;
  assign busy      = pending || boot_active;

  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      pending         <= 1'b0;
      req             <= 1'b0;
      data_read_valid <= 1'b0;
    end else begin
      data_read_valid <= 1'b0;
      if (capture) begin
        pending <= 1'b1;
        req     <= 1'b1;
      end else if (req && gnt) begin
        req <= 1'b0;
        // A write is finished once the RAM took it
        if (req_data.write) begin
          pending <= 1'b0;
        end
      end else if (read_done) begin
        pending         <= 1'b0;
        data_read_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      // Write wins when both strobes are present
      if (write_req) begin
        req_data <= '{write: 1'b1, read: 1'b0, addr: addr, wdata: data_write};
      end else begin
        req_data <= '{write: 1'b0, read: 1'b1, addr: addr, wdata: '0};
      end
    end
    if (read_done) begin
      data_read <= rsp.rdata;
    end
  end

endmodule

// File: verilog/ram_arbiter.sv
`timescale 1ns/1ns

module ram_arbiter (
  input  logic              clk,
  input  logic              reset_in,
  input  logic              boot_req,
  input  mem_pkg::ram_req_t boot_data,
  output logic              boot_gnt,
  input  logic              host_req,
  input  mem_pkg::ram_req_t host_data,
  output logic              host_gnt,
  output mem_pkg::ram_req_t ram_req,
  output logic              rsp_to_host
);

  logic owner_host;

  // Boot loader always goes first
  assign boot_gnt    = boot_req;
  assign host_gnt    = host_req && !boot_req;
  assign rsp_to_host = owner_host;

  always_comb begin
    ram_req = '0;
    if (boot_gnt) begin
      ram_req = boot_data;
    end else if (host_gnt) begin
      ram_req = host_data;
    end
  end

  // --------------------------------------------------
  // Owner of the read now in the RAM pipeline
  // --------------------------------------------------
  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      owner_host <= 1'b0;
    end else if (ram_req.read) begin
      owner_host <= host_gnt;
    end
  end

  assert property (@(posedge clk) disable iff (reset_in) !(boot_gnt && host_gnt))
    else $error("ram_arbiter: both ports granted");

endmodule

// File: verilog/word_ram.sv
`timescale 1ns/1ns

module word_ram (
  input  logic              clk,
  input  mem_pkg::ram_req_t ram_req,
  output mem_pkg::ram_rsp_t rsp
);

  localparam int depth = 2 ** mem_pkg::ram_addr_bits;

  logic [mem_pkg::data_width-1:0] mem [0:depth-1];

  // Write port
  always_ff @(posedge clk) begin
    if (ram_req.write) begin
      mem[ram_req.addr] <= ram_req.wdata;
    end
  end

  // Registered read, valid one cycle after the request
  always_ff @(posedge clk) begin
    if (ram_req.read) begin
      rsp.rdata <= mem[ram_req.addr];
    end
    rsp.rdata_valid <= ram_req.read;
  end

endmodule

// File: verilog/mem_top.sv
`timescale 1ns/1ns

module mem_top #(
  parameter int page_words = mem_pkg::page_words_default
) (
  input  logic                              clk,
  input  logic                              reset_in,
  input  logic                              write_req,
  input  logic                              read_req,
  input  logic [mem_pkg::ram_addr_bits-1:0] addr,
  input  logic [mem_pkg::data_width-1:0]    data_write,
  output logic [mem_pkg::data_width-1:0]    data_read,
  output logic                              data_read_valid,
  output logic                              busy,
  output logic                              flash_c,
  output logic                              flash_sb,
  output logic                              flash_dq0,
  input  logic                              flash_dq1
);

  // Flash link
  logic                                flash_start;
  logic [mem_pkg::flash_addr_bits-1:0] flash_addr;
  logic [9:0]                          flash_byte_count;
  logic                                flash_busy;
  logic [7:0]                          byte_data;
  logic                                byte_valid;

  // Shared RAM bus
  logic              boot_req;
  logic              boot_gnt;
  logic              host_req;
  logic              host_gnt;
  logic              rsp_to_host;
  logic              boot_active;
  mem_pkg::ram_req_t boot_data;
  mem_pkg::ram_req_t host_data;
  mem_pkg::ram_req_t ram_req;
  mem_pkg::ram_rsp_t ram_rsp;

  spi_flash_reader i_spi_flash_reader (
    .clk        (clk),
    .reset_in   (reset_in),
    .start      (flash_start),
    .addr       (flash_addr),
    .byte_count (flash_byte_count),
    .busy       (flash_busy),
    .byte_data  (byte_data),
    .byte_valid (byte_valid),
    .flash_c    (flash_c),
    .flash_sb   (flash_sb),
    .flash_dq0  (flash_dq0),
    .flash_dq1  (flash_dq1)
  );

  boot_loader #(
    .page_words (page_words)
  ) i_boot_loader (
    .clk              (clk),
    .reset_in         (reset_in),
    .flash_start      (flash_start),
    .flash_addr       (flash_addr),
    .flash_byte_count (flash_byte_count),
    .flash_busy       (flash_busy),
    .byte_data        (byte_data),
    .byte_valid       (byte_valid),
    .req              (boot_req),
    .req_data         (boot_data),
    .gnt              (boot_gnt),
    .boot_active      (boot_active)
  );

  host_port i_host_port (
    .clk             (clk),
    .reset_in        (reset_in),
    .write_req       (write_req),
    .read_req        (read_req),
    .addr            (addr),
    .data_write      (data_write),
    .data_read       (data_read),
    .data_read_valid (data_read_valid),
    .busy            (busy),
    .boot_active     (boot_active),
    .req             (host_req),
    .req_data        (host_data),
    .gnt             (host_gnt),
    .rsp             (ram_rsp),
    .rsp_mine        (rsp_to_host)
  );

  ram_arbiter i_ram_arbiter (
    .clk         (clk),
    .reset_in    (reset_in),
    .boot_req    (boot_req),
    .boot_data   (boot_data),
    .boot_gnt    (boot_gnt),
    .host_req    (host_req),
    .host_data   (host_data),
    .host_gnt    (host_gnt),
    .ram_req     (ram_req),
    .rsp_to_host (rsp_to_host)
  );

  word_ram i_word_ram (
    .clk     (clk),
    .ram_req (ram_req),
    .rsp     (ram_rsp)
  );

endmodule

// File: verif/flash_model.sv
`timescale 1ns/1ns

module flash_model #(
  parameter int image_words = 32
) (
  input  logic flash_c,
  input  logic flash_sb,
  input  logic flash_dq0,
  output logic flash_dq1
);

  logic [31:0] image [0:image_words-1];
  logic [31:0] in_sr;
  int          in_bits  = 0;
  int          out_bits = 0;
  logic [23:0] byte_addr;
  logic [7:0]  out_byte;

  initial begin
    $readmemh("verif/flash_stim.hex", image);
    flash_dq1 = 1'b0;
  end

  // Image starts at flash_base, words stored most significant byte first
  function automatic logic [7:0] read_byte(input logic [23:0] a);
    logic [23:0] offset;
    offset = a - mem_pkg::flash_base;
    if (offset[23:2] < image_words) begin
      read_byte = image[offset[23:2]][8 * (3 - offset[1:0]) +: 8];
    end else begin
      read_byte = 8'hff;
    end
  endfunction

  always @(posedge flash_c or negedge flash_c or posedge flash_sb) begin
    if (flash_sb) begin
      in_bits   = 0;
      out_bits  = 0;
      flash_dq1 = 1'b0;
    end else if (flash_c) begin
      // Rising edge takes command and address
      if (in_bits < 32) begin
        in_sr     = {in_sr[30:0], flash_dq0};
        in_bits   = in_bits + 1;
        byte_addr = in_sr[23:0];
      end
    end else if (in_bits == 32) begin
      // Falling edge moves the next data bit out
      if (out_bits == 0) begin
        out_byte = (in_sr[31:24] == mem_pkg::flash_read_cmd) ? read_byte(byte_addr) : 8'hff;
      end
      flash_dq1 = out_byte[7 - out_bits];
      out_bits  = out_bits + 1;
      if (out_bits == 8) begin
        out_bits  = 0;
        byte_addr = byte_addr + 24'd1;
      end
    end
  end

endmodule

// File: verif/mem_checker.sv
`timescale 1ns/1ns

module mem_checker #(
  parameter int page_words  = mem_pkg::page_words_default,
  parameter int image_words = 32
) (
  input  logic                           clk,
  input  logic                           reset_in,
  input  logic                           busy,
  input  logic [mem_pkg::data_width-1:0] data_read,
  input  logic                           data_read_valid,
  input  logic                           flash_c,
  input  logic                           flash_sb,
  input  logic                           flash_dq0,
  input  logic                           run_done,
  output logic                           checks_done,
  output int                             tests_run,
  output int                             errors
);

  localparam int ram_words = 2 ** mem_pkg::ram_addr_bits;

  logic [31:0]          image [0:image_words-1];
  logic [31:0]          model [0:ram_words-1];
  mem_pkg::image_word_u header;
  int                   exp_pages;

  // Expected read results in the order the host issues them
  logic [31:0]          exp_data_q[$];
  logic [7:0]           exp_addr_q[$];

  int                   n_tests     = 0;
  int                   n_errors    = 0;
  int                   stim_errors = 0;
  logic                 reset_seen  = 1'b0;
  logic                 booted      = 1'b0;
  logic                 final_done  = 1'b0;

  // Flash link decode
  logic                 prev_c  = 1'b0;
  logic                 prev_sb = 1'b1;
  logic [31:0]          cmd_sr;
  int                   cmd_bits;
  int                   pulses  = 0;
  logic [23:0]          exp_flash_addr;
  logic [7:0]           rd_addr;
  logic [31:0]          rd_data;

  assign tests_run   = n_tests;
  assign errors      = n_errors + stim_errors;
  assign checks_done = final_done;

  // --------------------------------------------------
  // Expectations from both data files
  // --------------------------------------------------
  initial begin
    int          fd;
    int          c;
    int          n;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    $readmemh("verif/flash_stim.hex", image);
    header.data = image[0];
    exp_pages   = header.header.page_count;
    for (int i = 0; i < exp_pages * page_words && i < image_words; i++) begin
      model[i] = image[i];
    end
    fd = $fopen("verif/host_stim.txt", "r");
    if (fd == 0) begin
      $display("Checker could not open verif/host_stim.txt for reading");
      stim_errors = stim_errors + 1;
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
          end
        end else if (c == "R" || c == "W" || c == "I" || c == "V") begin
          n = $fscanf(fd, "%h %h %h", a, d, e);
          if (n != 3) begin
            $display("Checker found host stimulus line %c with %0d of its 3 fields", c, n);
            stim_errors = stim_errors + 1;
          end else if (c == "W") begin
            model[a[7:0]] = d;
          end else if (c == "V") begin
            for (int k = 0; k < d; k++) begin
              exp_addr_q.push_back(a + k);
              exp_data_q.push_back(model[a[7:0] + k]);
            end
          end else if (c == "R") begin
            if (model[a[7:0]] !== e) begin
              $display("Stimulus error: read of %h lists %h, but image and writes give %h",
                       a[7:0], e, model[a[7:0]]);
              stim_errors = stim_errors + 1;
            end
            exp_addr_q.push_back(a[7:0]);
            exp_data_q.push_back(model[a[7:0]]);
          end
          // I lines leave the memory alone
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  end

  always @(posedge clk) begin
    if (!reset_in) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        n_tests    = n_tests + 1;
        if (busy !== 1'b1) begin
          $display("Error at %0t ns: busy = %b, expected 1", $time, busy);
          n_errors = n_errors + 1;
        end else if (flash_sb !== 1'b1) begin
          $display("Error at %0t ns: flash_sb = %b, expected 1", $time, flash_sb);
          n_errors = n_errors + 1;
        end else begin
          $display("Test reset state: ok");
        end
      end

      if (!booted) begin
        if (data_read_valid) begin
          $display("data_read_valid rose at %0t ns before boot had finished", $time);
          n_errors = n_errors + 1;
        end
        if (!busy) begin
          booted  = 1'b1;
          n_tests = n_tests + 1;
          $display("Test boot end: busy fell at %0t ns", $time);
        end
      end

      // Command and address bits are taken on rising flash_c
      if (prev_sb && !flash_sb) begin
        cmd_sr   = '0;
        cmd_bits = 0;
      end else if (!flash_sb && flash_c && !prev_c && cmd_bits < 32) begin
        cmd_sr   = {cmd_sr[30:0], flash_dq0};
        cmd_bits = cmd_bits + 1;
      end else if (!prev_sb && flash_sb) begin
        exp_flash_addr = mem_pkg::flash_base + 24'(pulses * page_words * 4);
        n_tests        = n_tests + 1;
        if (cmd_bits < 32) begin
          $display("Flash transfer %0d ended after %0d command bits", pulses, cmd_bits);
          n_errors = n_errors + 1;
        end else if (cmd_sr[31:24] !== mem_pkg::flash_read_cmd) begin
          $display("Error at %0t ns: flash_dq0 command = %h, expected %h",
                   $time, cmd_sr[31:24], mem_pkg::flash_read_cmd);
          n_errors = n_errors + 1;
        end else if (cmd_sr[23:0] !== exp_flash_addr) begin
          $display("Error at %0t ns: flash_dq0 address = %h, expected %h",
                   $time, cmd_sr[23:0], exp_flash_addr);
          n_errors = n_errors + 1;
        end else begin
          $display("Test flash transfer %0d: cmd %h addr %h ok", pulses, cmd_sr[31:24],
                   cmd_sr[23:0]);
        end
        pulses = pulses + 1;
      end
      prev_c  = flash_c;
      prev_sb = flash_sb;

      if (data_read_valid) begin
        n_tests = n_tests + 1;
        if (exp_data_q.size() == 0) begin
          $display("data_read_valid at %0t ns with no read outstanding", $time);
          n_errors = n_errors + 1;
        end else begin
          rd_addr = exp_addr_q.pop_front();
          rd_data = exp_data_q.pop_front();
          if (data_read !== rd_data) begin
            $display("Error at %0t ns: data_read = %h, expected %h (address %h)",
                     $time, data_read, rd_data, rd_addr);
            n_errors = n_errors + 1;
          end else begin
            $display("Test read %h: %h ok", rd_addr, data_read);
          end
        end
      end

      // --------------------------------------------------
      // End of run
      // --------------------------------------------------
      if (run_done && !final_done) begin
        n_tests = n_tests + 1;
        if (!booted) begin
          $display("busy never fell after reset");
          n_errors = n_errors + 1;
        end else if (pulses != exp_pages) begin
          $display("Error at %0t ns: flash_sb pulses = %0d, expected %0d",
                   $time, pulses, exp_pages);
          n_errors = n_errors + 1;
        end else begin
          $display("Test flash transfer count: %0d ok", pulses);
        end
        n_tests = n_tests + 1;
        if (exp_data_q.size() != 0) begin
          $display("%0d accepted reads ended without data_read_valid", exp_data_q.size());
          n_errors = n_errors + 1;
        end else begin
          $display("Test read count: ok");
        end
        final_done = 1'b1;
      end
    end
  end

endmodule

// File: verif/mem_top_tb.sv
`timescale 1ns/1ns

module mem_top_tb;

  localparam int page_words  = mem_pkg::page_words_default;
  localparam int image_words = 2 * page_words;

  logic                                 clk;
  logic                                 reset_in;
  logic                                 write_req;
  logic                                 read_req;
  logic [mem_pkg::ram_addr_bits-1:0]    addr;
  logic [mem_pkg::data_width-1:0]       data_write;
  logic [mem_pkg::data_width-1:0]       data_read;
  logic                                 data_read_valid;
  logic                                 busy;
  logic                                 flash_c;
  logic                                 flash_sb;
  logic                                 flash_dq0;
  logic                                 flash_dq1;

  logic                                 run_done;
  logic                                 checks_done;
  int                                   tests_run;
  int                                   check_errors;
  int                                   tb_errors   = 0;
  int                                   cycles      = 0;
  int                                   cycle_limit = 0;

  // Host operations with V lines already expanded into reads
  byte                                  op_q[$];
  logic [mem_pkg::ram_addr_bits-1:0]    addr_q[$];
  logic [mem_pkg::data_width-1:0]       data_q[$];
  logic [mem_pkg::data_width-1:0]       image [0:image_words-1];
  mem_pkg::image_word_u                 header;

  mem_top #(
    .page_words (page_words)
  ) i_mem_top (
    .clk             (clk),
    .reset_in        (reset_in),
    .write_req       (write_req),
    .read_req        (read_req),
    .addr            (addr),
    .data_write      (data_write),
    .data_read       (data_read),
    .data_read_valid (data_read_valid),
    .busy            (busy),
    .flash_c         (flash_c),
    .flash_sb        (flash_sb),
    .flash_dq0       (flash_dq0),
    .flash_dq1       (flash_dq1)
  );

  flash_model #(
    .image_words (image_words)
  ) i_flash_model (
    .flash_c   (flash_c),
    .flash_sb  (flash_sb),
    .flash_dq0 (flash_dq0),
    .flash_dq1 (flash_dq1)
  );

  mem_checker #(
    .page_words  (page_words),
    .image_words (image_words)
  ) i_mem_checker (
    .clk             (clk),
    .reset_in        (reset_in),
    .busy            (busy),
    .data_read       (data_read),
    .data_read_valid (data_read_valid),
    .flash_c         (flash_c),
    .flash_sb        (flash_sb),
    .flash_dq0       (flash_dq0),
    .run_done        (run_done),
    .checks_done     (checks_done),
    .tests_run       (tests_run),
    .errors          (check_errors)
  );

  always #2 clk = ~clk;

  // --------------------------------------------------
  // Timeout
  // --------------------------------------------------
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (!reset_in && cycles > cycle_limit) begin
      $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // Each line holds op addr data expected and # starts a comment
  task automatic load_host_ops;
    int                             fd;
    int                             c;
    int                             n;
    logic [31:0]                    a;
    logic [31:0]                    d;
    logic [31:0]                    e;
    fd = $fopen("verif/host_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/host_stim.txt for reading");
      tb_errors = tb_errors + 1;
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
          end
        end else if (c == "R" || c == "W" || c == "I" || c == "V") begin
          n = $fscanf(fd, "%h %h %h", a, d, e);
          if (n != 3) begin
            $display("Host stimulus line %c holds %0d of its 3 fields", c, n);
            tb_errors = tb_errors + 1;
          end else if (c == "V") begin
            for (int k = 0; k < d; k++) begin
              op_q.push_back("R");
              addr_q.push_back(a + k);
              data_q.push_back('0);
            end
          end else begin
            op_q.push_back(c);
            addr_q.push_back(a);
            data_q.push_back(d);
          end
        end
        c = $fgetc(fd);
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_idle;
    while (busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    byte                               op;
    logic [mem_pkg::ram_addr_bits-1:0] a;
    logic [mem_pkg::data_width-1:0]    d;
    clk        = 1'b0;
    reset_in   = 1'b1;
    write_req  = 1'b0;
    read_req   = 1'b0;
    addr       = '0;
    data_write = '0;
    run_done   = 1'b0;
    $readmemh("verif/flash_stim.hex", image);
    header.data = image[0];
    load_host_ops();
    cycle_limit = 2 * header.header.page_count * (page_words * 64 + 40) + 20 * op_q.size();

    repeat (2) @(posedge clk);
    #1;
    reset_in = 1'b0;

    while (op_q.size() > 0) begin
      op = op_q.pop_front();
      a  = addr_q.pop_front();
      d  = data_q.pop_front();
      // I strobes go out right away into the previous operation
      if (op == "I") begin
        if (!busy) begin
          $display("Stimulus error: write to %h should meet a busy port, but busy is low", a);
          tb_errors = tb_errors + 1;
        end
      end else begin
        wait_idle();
      end
      addr       = a;
      data_write = d;
      write_req  = (op != "R");
      read_req   = (op == "R");
      @(posedge clk);
      #1;
      write_req = 1'b0;
      read_req  = 1'b0;
    end

    wait_idle();
    run_done = 1'b1;
    while (!checks_done) begin
      @(posedge clk);
      #1;
    end
    $display("Tests run: %0d, errors: %0d", tests_run, check_errors + tb_errors);
    if (check_errors + tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verif/flash_stim.hex
// One 32-bit image word per line, from flash byte address 080000 hex onward
// Word 0 is the header, reserved in bits 31:16 and page_count in bits 15:0
5a5a0002
01234567
89abcdef
13579bdf
2468ace0
f0e1d2c3
b4a59687
78695a4b
3c2d1e0f
0f1e2d3c
4b5a6978
8796a5b4
c3d2e1f0
deadbeef
feedface
0badf00d
10203040
50607080
90a0b0c0
d0e0f001
11223344
55667788
99aabbcc
ddeeff00
a5a5c3c3
5a5a3c3c
c0ffee11
12211221
76543210
fedcba98
31415926
27182818

// File: verif/host_stim.txt
# op addr data expected, all hex; R read, W write, I write strobed while busy is high
# V reads data words from addr on and expects the flash image there
V 00 00000020 00000000
R 00 00000000 5a5a0002
R 1f 00000000 27182818
W 40 cafe0040 00000000
R 40 00000000 cafe0040
W 05 a1b2c3d4 00000000
R 05 00000000 a1b2c3d4
I 05 deadbeef 00000000
R 05 00000000 a1b2c3d4
W 20 0000beef 00000000
I 20 11111111 00000000
R 20 00000000 0000beef
R 10 00000000 10203040

// File: compile.f
verilog/mem_pkg.sv
verilog/spi_flash_reader.sv
verilog/boot_loader.sv
verilog/host_port.sv
verilog/ram_arbiter.sv
verilog/word_ram.sv
verilog/mem_top.sv
verif/flash_model.sv
verif/mem_checker.sv
verif/mem_top_tb.sv
